// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // Widths that carry a meaning across the core.
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes of the RV32I base set that the core understands.
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // ALU operation codes.
  // ALU_COPY_B passes operand B through, which is how LUI gets its value.
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_COPY_B = 4'd10;

  // Branch conditions as they appear in funct3.
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // The only CSR instruction that is implemented.
  localparam funct3_t F3_CSRRW = 3'b001;

  // Access widths, taken from funct3[1:0] of loads and stores.
  // funct3[2] marks an unsigned load.
  localparam logic [1:0] MEM_BYTE = 2'b00;
  localparam logic [1:0] MEM_HALF = 2'b01;
  localparam logic [1:0] MEM_WORD = 2'b10;

  // The testbench watches this CSR for results.
  localparam logic [11:0] CSR_TOHOST = 12'h51E;

  // Address of the first fetch after reset.
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== rtl/rv_decode.sv ====
`default_nettype none

module rv_decode import rv_pkg::*; (
  input  word_t    instr,
  output alu_op_t  alu_op,
  output funct3_t  funct3,
  output logic     a_sel,
  output logic     b_sel,
  output logic     is_jump,
  output logic     is_branch,
  output logic     reg_we,
  output logic     mem_we,
  output logic     mem_rr,
  output logic     csr_write,
  output reg_idx_t rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output word_t    imm
);

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  // Maps funct3 onto an ALU operation.
  // The alt bit is instr[30]; it selects SUB and SRA.
  function automatic alu_op_t alu_from_funct3(funct3_t f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Register fields sit at fixed positions in every format.
  // Formats that lack a field just leave it unused downstream.
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // All five immediate formats, sign extended from bit 31.
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // Anything not matched below decodes as a no-op with every enable low.
    alu_op    = ALU_ADD;
    a_sel     = 1'b0;
    b_sel     = 1'b1;
    is_jump   = 1'b0;
    is_branch = 1'b0;
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    mem_rr    = 1'b0;
    csr_write = 1'b0;
    imm       = imm_i;
    case (opcode)
      OP_LUI: begin
        alu_op = ALU_COPY_B;
        imm    = imm_u;
        reg_we = 1'b1;
      end
      OP_AUIPC: begin
        a_sel  = 1'b1;
        imm    = imm_u;
        reg_we = 1'b1;
      end
      // For jumps and branches the adder forms the target.
      // Execute replaces the result of a jump with the link address.
      OP_JAL: begin
        a_sel   = 1'b1;
        imm     = imm_j;
        is_jump = 1'b1;
        reg_we  = 1'b1;
      end
      OP_JALR: begin
        is_jump = 1'b1;
        reg_we  = 1'b1;
      end
      OP_BRANCH: begin
        a_sel     = 1'b1;
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        mem_rr = 1'b1;
        reg_we = 1'b1;
      end
      OP_STORE: begin
        imm    = imm_s;
        mem_we = 1'b1;
      end
      OP_IMM: begin
        // Only the shifts use bit 30; ADDI never subtracts.
        alu_op = alu_from_funct3(funct3, instr[30] && funct3 == 3'b101);
        reg_we = 1'b1;
      end
      OP_REG: begin
        alu_op = alu_from_funct3(funct3, instr[30]);
        b_sel  = 1'b0;
        reg_we = 1'b1;
      end
      OP_SYSTEM: begin
        // CSRRW to tohost passes rs1 through the adder with a zero immediate.
        // The old CSR value is not returned, so rd is never written.
        imm       = '0;
        csr_write = (funct3 == F3_CSRRW) && (instr[31:20] == CSR_TOHOST);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     stall,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  input  logic     we,
  input  reg_idx_t wa,
  input  word_t    wd,
  output word_t    rd1,
  output word_t    rd2
);

  word_t regs [32];

  // Value seen by a read port at this edge.
  // A write to the same index lands in the latch, and x0 always reads as zero.
  function automatic word_t read_port(reg_idx_t ra, word_t stored);
    if (ra == '0) begin
      return '0;
    end
    if (we && wa == ra) begin
      return wd;
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    // The whole file freezes with the pipeline.
    if (!stall) begin
      if (we && wa != '0) begin
        regs[wa] <= wd;
      end
      rd1 <= read_port(ra1, regs[ra1]);
      rd2 <= read_port(ra2, regs[ra2]);
    end
  end

  // x0 reads zero one cycle later even though its entry is never written.
  a_x0_reads_zero: assert property (@(posedge clk) (!stall && ra1 == '0) |=> (rd1 == '0))
    else $error("rv_regfile: x0 read returned a nonzero value");

endmodule

`default_nettype wire

// ==== rtl/rv_execute.sv ====
`default_nettype none

module rv_execute import rv_pkg::*; (
  input  word_t    pc,
  input  word_t    reg_a,
  input  word_t    reg_b,
  input  word_t    imm,
  input  word_t    wb_value,
  input  alu_op_t  alu_op,
  input  funct3_t  funct3,
  input  logic     a_sel,
  input  logic     b_sel,
  input  logic     is_jump,
  input  logic     is_branch,
  input  logic     mem_we,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t wb_rd,
  input  logic     wb_we,
  output logic     do_jump,
  output word_t    result,
  output word_t    store_data,
  output word_t    store_address,
  output byte_en_t byte_en
);

  word_t fwd_a;
  word_t fwd_b;
  word_t alu_a;
  word_t alu_b;
  word_t sum;
  word_t alu_out;
  logic  taken;
  logic  aligned;

  // Evaluates a branch condition on the forwarded register operands.
  function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // The instruction in writeback is the only one not yet in the register file.
  // Loads are covered too, since their data arrives during writeback.
  assign fwd_a = (wb_we && wb_rd != '0 && wb_rd == rs1) ? wb_value : reg_a;
  assign fwd_b = (wb_we && wb_rd != '0 && wb_rd == rs2) ? wb_value : reg_b;

  assign alu_a = a_sel ? pc : fwd_a;
  assign alu_b = b_sel ? imm : fwd_b;

  // The adder serves ADD, memory addresses and jump targets alike.
  assign sum = alu_a + alu_b;

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = sum;
      ALU_SUB:    alu_out = alu_a - alu_b;
      ALU_SLL:    alu_out = alu_a << alu_b[4:0];
      ALU_SLT:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_out = {31'b0, alu_a < alu_b};
      ALU_XOR:    alu_out = alu_a ^ alu_b;
      ALU_SRL:    alu_out = alu_a >> alu_b[4:0];
      ALU_SRA:    alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
      ALU_OR:     alu_out = alu_a | alu_b;
      ALU_AND:    alu_out = alu_a & alu_b;
      ALU_COPY_B: alu_out = alu_b;
      default:    alu_out = sum;
    endcase
  end

  assign taken   = branch_taken(funct3, fwd_a, fwd_b);
  assign do_jump = is_jump || (is_branch && taken);

  // Jumps write back the link address.
  assign result = is_jump ? pc + 32'd4 : alu_out;

  // One output carries both the data address and the jump target.
  // JALR clears bit 0 of its target; JAL and branch targets are even anyway.
  assign store_address = is_jump ? {sum[31:1], 1'b0} : sum;

  // Store data moves into the lane of the low address bits.
  // Bytes outside the lane are masked by the enables.
  assign store_data = fwd_b << {sum[1:0], 3'b000};

  always_comb begin
    byte_en = '0;
    if (mem_we) begin
      case (funct3[1:0])
        MEM_BYTE: byte_en = 4'b0001 << sum[1:0];
        MEM_HALF: byte_en = 4'b0011 << sum[1:0];
        MEM_WORD: byte_en = 4'b1111;
        default:  byte_en = '0;
      endcase
    end
  end

  always_comb begin
    case (funct3[1:0])
      MEM_HALF: aligned = (sum[0] == 1'b0);
      MEM_WORD: aligned = (sum[1:0] == 2'b00);
      default:  aligned = 1'b1;
    endcase
  end

  // Misaligned accesses are not supported.
  // A program that issues one would see a truncated write.
  always_comb begin
    if (byte_en != '0) begin
      a_store_aligned: assert (aligned)
        else $error("rv_execute: misaligned store to %h", sum);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_writeback.sv ====
`default_nettype none

module rv_writeback import rv_pkg::*; (
  input  word_t   pc,
  input  word_t   alu_result,
  input  word_t   mem_data,
  input  funct3_t funct3,
  input  logic    mem_rr,
  input  logic    do_jump,
  output word_t   value
);

  word_t lane;
  word_t loaded;

  // The low bits of the address pick the byte lane.
  // Shifting right puts the wanted data at bit 0.
  assign lane = mem_data >> {alu_result[1:0], 3'b000};

  always_comb begin
    case (funct3[1:0])
      MEM_BYTE: begin
        loaded = funct3[2] ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      end
      MEM_HALF: begin
        loaded = funct3[2] ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      end
      default: begin
        loaded = mem_data;
      end
    endcase
  end

  // A taken jump links to the instruction after it.
  // Taken branches also raise do_jump but never write a register, so the value is unused.
  always_comb begin
    if (mem_rr) begin
      value = loaded;
    end else if (do_jump) begin
      value = pc + 32'd4;
    end else begin
      value = alu_result;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    icache_dout,
  input  word_t    dcache_dout,
  input  logic     stall,
  output word_t    icache_addr,
  output word_t    dcache_addr,
  output word_t    dcache_din,
  output logic     icache_re,
  output logic     dcache_re,
  output byte_en_t dcache_we,
  output word_t    csr
);

  // High for the cycle after reset.
  // The fetch of RESET_PC needs that cycle before its word is on icache_dout.
  logic reset_hold;
  logic internal_stall;

  // Suffix 1 is decode, 2 is execute and 3 is writeback.
  word_t    pc_1, pc_2, pc_3;
  word_t    next_pc;
  word_t    jump_target;

  alu_op_t  alu_op_1, alu_op_2;
  funct3_t  funct3_1, funct3_2, funct3_3;
  logic     a_sel_1, a_sel_2;
  logic     b_sel_1, b_sel_2;
  logic     is_jump_1, is_jump_2;
  logic     is_branch_1, is_branch_2;
  logic     reg_we_1, reg_we_2, reg_we_3;
  logic     mem_we_1, mem_we_2;
  logic     mem_rr_1, mem_rr_2, mem_rr_3;
  logic     csr_write_1, csr_write_2, csr_write_3;
  logic     do_jump_2, do_jump_3;
  reg_idx_t rd_1, rd_2, rd_3;
  reg_idx_t rs1_1, rs1_2;
  reg_idx_t rs2_1, rs2_2;
  word_t    imm_1, imm_2;
  word_t    reg_a_2, reg_b_2;
  word_t    result_2, result_3;
  word_t    wb_value;

  assign internal_stall = stall || reset_hold;

  always_ff @(posedge clk) begin
    reset_hold <= reset;
  end

  // The instruction port reads every cycle.
  // The address is next_pc, so the word shows up when pc_1 holds that address.
  assign icache_re   = 1'b1;
  assign icache_addr = next_pc;

  // A stalled fetch repeats its address so the returned word still matches pc_1.
  assign next_pc = do_jump_2 ? jump_target : (internal_stall ? pc_1 : pc_1 + 32'd4);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_1 <= RESET_PC;
    end else if (!internal_stall) begin
      pc_1 <= next_pc;
    end
  end

  rv_decode u_decode (
    .instr     (icache_dout),
    .alu_op    (alu_op_1),
    .funct3    (funct3_1),
    .a_sel     (a_sel_1),
    .b_sel     (b_sel_1),
    .is_jump   (is_jump_1),
    .is_branch (is_branch_1),
    .reg_we    (reg_we_1),
    .mem_we    (mem_we_1),
    .mem_rr    (mem_rr_1),
    .csr_write (csr_write_1),
    .rd        (rd_1),
    .rs1       (rs1_1),
    .rs2       (rs2_1),
    .imm       (imm_1)
  );

  // Its read latches play the part of the decode to execute operand registers.
  rv_regfile u_regfile (
    .clk   (clk),
    .stall (internal_stall),
    .ra1   (rs1_1),
    .ra2   (rs2_1),
    .we    (reg_we_3),
    .wa    (rd_3),
    .wd    (wb_value),
    .rd1   (reg_a_2),
    .rd2   (reg_b_2)
  );

  // Payload into execute.
  // Stale values are harmless because the flags below decide what takes effect.
  always_ff @(posedge clk) begin
    if (!internal_stall) begin
      pc_2     <= pc_1;
      alu_op_2 <= alu_op_1;
      funct3_2 <= funct3_1;
      a_sel_2  <= a_sel_1;
      b_sel_2  <= b_sel_1;
      rd_2     <= rd_1;
      rs1_2    <= rs1_1;
      rs2_2    <= rs2_1;
      imm_2    <= imm_1;
    end
  end

  // Execute flags.
  // A taken jump turns the instruction fetched behind it into a bubble.
  always_ff @(posedge clk) begin
    if (reset || (do_jump_2 && !internal_stall)) begin
      is_jump_2   <= 1'b0;
      is_branch_2 <= 1'b0;
      reg_we_2    <= 1'b0;
      mem_we_2    <= 1'b0;
      mem_rr_2    <= 1'b0;
      csr_write_2 <= 1'b0;
    end else if (!internal_stall) begin
      is_jump_2   <= is_jump_1;
      is_branch_2 <= is_branch_1;
      reg_we_2    <= reg_we_1;
      mem_we_2    <= mem_we_1;
      mem_rr_2    <= mem_rr_1;
      csr_write_2 <= csr_write_1;
    end
  end

  rv_execute u_execute (
    .pc            (pc_2),
    .reg_a         (reg_a_2),
    .reg_b         (reg_b_2),
    .imm           (imm_2),
    .wb_value      (wb_value),
    .alu_op        (alu_op_2),
    .funct3        (funct3_2),
    .a_sel         (a_sel_2),
    .b_sel         (b_sel_2),
    .is_jump       (is_jump_2),
    .is_branch     (is_branch_2),
    .mem_we        (mem_we_2),
    .rs1           (rs1_2),
    .rs2           (rs2_2),
    .wb_rd         (rd_3),
    .wb_we         (reg_we_3),
    .do_jump       (do_jump_2),
    .result        (result_2),
    .store_data    (dcache_din),
    .store_address (jump_target),
    .byte_en       (dcache_we)
  );

  // The data address is the same adder output as the jump target.
  assign dcache_addr = jump_target;
  assign dcache_re   = mem_rr_2;

  always_ff @(posedge clk) begin
    if (!internal_stall) begin
      pc_3     <= pc_2;
      funct3_3 <= funct3_2;
      rd_3     <= rd_2;
      result_3 <= result_2;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_we_3    <= 1'b0;
      mem_rr_3    <= 1'b0;
      csr_write_3 <= 1'b0;
      do_jump_3   <= 1'b0;
    end else if (!internal_stall) begin
      reg_we_3    <= reg_we_2;
      mem_rr_3    <= mem_rr_2;
      csr_write_3 <= csr_write_2;
      do_jump_3   <= do_jump_2;
    end
  end

  // Load data from the synchronous data port arrives in this stage.
  rv_writeback u_writeback (
    .pc         (pc_3),
    .alu_result (result_3),
    .mem_data   (dcache_dout),
    .funct3     (funct3_3),
    .mem_rr     (mem_rr_3),
    .do_jump    (do_jump_3),
    .value      (wb_value)
  );

  // tohost takes its value at the edge that ends writeback.
  always_ff @(posedge clk) begin
    if (reset) begin
      csr <= '0;
    end else if (!internal_stall && csr_write_3) begin
      csr <= wb_value;
    end
  end

  // Decode never sets both memory flags, and the bubble clears them together.
  a_no_read_and_write: assert property (
    @(posedge clk) disable iff (reset) !(dcache_re && dcache_we != '0)
  ) else $error("rv_core: data port read and write in the same cycle");

endmodule

`default_nettype wire

// ==== tests/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUDGET = 400;
  localparam int RUNS = 7;
  localparam int WATCHDOG_NS = (RUNS * BUDGET + 200) * 20 * 2;

  logic     clk = 1'b0;
  logic     reset;
  logic     stall;
  logic     stall_mode;
  word_t    icache_dout;
  word_t    dcache_dout;
  word_t    icache_addr;
  word_t    dcache_addr;
  word_t    dcache_din;
  logic     icache_re;
  logic     dcache_re;
  byte_en_t dcache_we;
  word_t    csr;

  word_t    mem [2048];
  byte_en_t we_log [$];
  integer   seed = 32'h0c04ebf5;
  int       errors;
  int       wp;

  rv_core uut (
    .clk         (clk),
    .reset       (reset),
    .icache_dout (icache_dout),
    .dcache_dout (dcache_dout),
    .stall       (stall),
    .icache_addr (icache_addr),
    .dcache_addr (dcache_addr),
    .dcache_din  (dcache_din),
    .icache_re   (icache_re),
    .dcache_re   (dcache_re),
    .dcache_we   (dcache_we),
    .csr         (csr)
  );

  always #10 clk = ~clk;

  // Both ports read with one cycle of latency when their read enable is high.
  // They hold their outputs while stalled.
  always @(posedge clk) begin
    if (!stall) begin
      if (icache_re) begin
        icache_dout <= mem[icache_addr[12:2]];
      end
      if (dcache_re) begin
        dcache_dout <= mem[dcache_addr[12:2]];
      end
      for (int b = 0; b < 4; b++) begin
        if (dcache_we[b]) begin
          mem[dcache_addr[12:2]][b*8 +: 8] <= dcache_din[b*8 +: 8];
        end
      end
      if (dcache_we != '0) begin
        we_log.push_back(dcache_we);
      end
    end
  end

  // Random stall cycles, never during reset.
  always @(posedge clk) begin
    #1;
    stall = stall_mode && !reset && (($random(seed) & 3) == 0);
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed.");
    $display("TEST FAILED");
    $finish;
  end

  function automatic word_t fill_word(int idx);
    return (word_t'(idx) * 32'h9E3779B9) ^ 32'hC3A5_0F1E;
  endfunction

  function automatic word_t r_type(logic [6:0] f7, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                   reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t i_type(opcode_t op, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(opcode_t op, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_byte_en(input string name, input byte_en_t expected,
                               input byte_en_t actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic put(input word_t instr);
    mem[wp] <= instr;
    wp++;
  endtask

  // Holds the core in reset and refills the whole memory before a program is placed.
  task automatic start_program();
    @(posedge clk);
    #1 reset = 1'b1;
    for (int i = 0; i < 2048; i++) begin
      mem[i] <= fill_word(i);
    end
    wp = 0;
    we_log.delete();
  endtask

  // Writes rs to tohost and then spins on a jump to itself.
  task automatic finish_program(input reg_idx_t rs);
    put(i_type(OP_SYSTEM, F3_CSRRW, 5'd0, rs, CSR_TOHOST));
    put(j_type(5'd0, 21'd0));
  endtask

  task automatic run_program(input string name, input word_t expected);
    int cycles;
    cycles = 0;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    while (csr == '0 && cycles < BUDGET) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (csr == '0) begin
      $display("%s: tohost was not written within %0d cycles.", name, BUDGET);
      errors++;
    end else begin
      check_word(name, expected, csr);
    end
  endtask

  task automatic reset_state();
    start_program();
    finish_program(5'd0);
    @(posedge clk);
    #2;
    check_word("reset csr", '0, csr);
    check_byte_en("reset dcache_we", '0, dcache_we);
    check_flag("reset dcache_re", 1'b0, dcache_re);
    check_flag("reset icache_re", 1'b1, icache_re);
    check_word("reset icache_addr", RESET_PC, icache_addr);
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    #4;
    check_word("post reset csr", '0, csr);
    check_byte_en("post reset dcache_we", '0, dcache_we);
    check_flag("post reset dcache_re", 1'b0, dcache_re);
    check_word("post reset icache_addr", RESET_PC, icache_addr);
  endtask

  // Back to back dependent ALU work, summed into x25.
  task automatic alu_chain(input string name);
    word_t r [32];
    word_t acc;
    int srcs [19] = '{3, 4, 5, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 18, 19, 21, 22, 23};
    start_program();
    put(u_type(OP_LUI, 5'd1, 20'h12345));
    put(i_type(OP_IMM, 3'd0, 5'd1, 5'd1, 12'h678));
    put(i_type(OP_IMM, 3'd0, 5'd2, 5'd0, 12'hFFB));
    put(r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
    put(r_type(7'h20, 3'd0, 5'd4, 5'd3, 5'd2));
    put(i_type(OP_IMM, 3'd0, 5'd6, 5'd0, 12'd7));
    put(r_type(7'h00, 3'd1, 5'd5, 5'd4, 5'd6));
    put(r_type(7'h00, 3'd5, 5'd7, 5'd5, 5'd6));
    put(i_type(OP_IMM, 3'd5, 5'd8, 5'd2, {7'h20, 5'd1}));
    put(i_type(OP_IMM, 3'd4, 5'd16, 5'd1, 12'hFFF));
    put(r_type(7'h20, 3'd5, 5'd9, 5'd16, 5'd6));
    put(r_type(7'h00, 3'd2, 5'd10, 5'd2, 5'd1));
    put(r_type(7'h00, 3'd3, 5'd11, 5'd2, 5'd1));
    put(i_type(OP_IMM, 3'd2, 5'd17, 5'd2, 12'hFFC));
    put(i_type(OP_IMM, 3'd3, 5'd18, 5'd1, 12'hFFF));
    put(r_type(7'h00, 3'd4, 5'd12, 5'd5, 5'd9));
    put(r_type(7'h00, 3'd6, 5'd13, 5'd12, 5'd10));
    put(r_type(7'h00, 3'd7, 5'd14, 5'd13, 5'd7));
    r[15] = word_t'(wp * 4) + 32'h1000;
    put(u_type(OP_AUIPC, 5'd15, 20'h1));
    put(i_type(OP_IMM, 3'd5, 5'd19, 5'd16, {7'h00, 5'd4}));
    put(i_type(OP_IMM, 3'd7, 5'd21, 5'd16, 12'h0F0));
    put(i_type(OP_IMM, 3'd6, 5'd22, 5'd1, 12'h00F));
    put(i_type(OP_IMM, 3'd1, 5'd23, 5'd8, {7'h00, 5'd3}));
    put(i_type(OP_IMM, 3'd0, 5'd25, 5'd0, 12'd0));
    foreach (srcs[i]) begin
      put(r_type(7'h00, 3'd0, 5'd25, 5'd25, reg_idx_t'(srcs[i])));
    end
    finish_program(5'd25);

    // Reference values follow the RV32I definitions of each operation.
    r[1]  = 32'h12345678;
    r[2]  = 32'hFFFFFFFB;
    r[3]  = r[1] + r[2];
    r[4]  = r[3] - r[2];
    r[6]  = 32'd7;
    r[5]  = r[4] << 7;
    r[7]  = r[5] >> 7;
    r[8]  = $signed(r[2]) >>> 1;
    r[16] = r[1] ^ 32'hFFFFFFFF;
    r[9]  = $signed(r[16]) >>> 7;
    r[10] = {31'b0, $signed(r[2]) < $signed(r[1])};
    r[11] = {31'b0, r[2] < r[1]};
    r[17] = {31'b0, $signed(r[2]) < $signed(32'hFFFFFFFC)};
    r[18] = {31'b0, r[1] < 32'hFFFFFFFF};
    r[12] = r[5] ^ r[9];
    r[13] = r[12] | r[10];
    r[14] = r[13] & r[7];
    r[19] = r[16] >> 4;
    r[21] = r[16] & 32'h0F0;
    r[22] = r[1] | 32'h00F;
    r[23] = r[8] << 3;
    acc = '0;
    foreach (srcs[i]) begin
      acc = acc + r[srcs[i]];
    end
    run_program(name, acc);
  endtask

  function automatic word_t sext8(logic [7:0] b);
    return {{24{b[7]}}, b};
  endfunction

  function automatic word_t sext16(logic [15:0] h);
    return {{16{h[15]}}, h};
  endfunction

  // Stores into words 1024 to 1027, then loads back with immediate use.
  task automatic load_store(input string name);
    word_t    v;
    word_t    old2;
    word_t    old3;
    word_t    e [4];
    word_t    sum;
    byte_en_t be [6] = '{4'b1111, 4'b0010, 4'b1000, 4'b1100, 4'b0011, 4'b0100};
    start_program();
    put(u_type(OP_LUI, 5'd1, 20'h00001));
    put(u_type(OP_LUI, 5'd2, 20'h89ABC));
    put(i_type(OP_IMM, 3'd0, 5'd2, 5'd2, 12'h5EF));
    put(s_type(3'd2, 5'd1, 5'd2, 12'd0));
    put(s_type(3'd0, 5'd1, 5'd2, 12'd5));
    put(s_type(3'd0, 5'd1, 5'd2, 12'd7));
    put(s_type(3'd1, 5'd1, 5'd2, 12'd10));
    put(s_type(3'd1, 5'd1, 5'd2, 12'd12));
    put(s_type(3'd0, 5'd1, 5'd2, 12'd14));
    put(i_type(OP_LOAD, 3'd2, 5'd3, 5'd1, 12'd0));
    put(i_type(OP_LOAD, 3'd0, 5'd4, 5'd1, 12'd5));
    put(r_type(7'h00, 3'd0, 5'd9, 5'd3, 5'd4));
    put(i_type(OP_LOAD, 3'd4, 5'd5, 5'd1, 12'd7));
    put(r_type(7'h00, 3'd0, 5'd9, 5'd9, 5'd5));
    put(i_type(OP_LOAD, 3'd1, 5'd6, 5'd1, 12'd10));
    put(r_type(7'h00, 3'd0, 5'd9, 5'd9, 5'd6));
    put(i_type(OP_LOAD, 3'd5, 5'd7, 5'd1, 12'd12));
    put(r_type(7'h00, 3'd0, 5'd9, 5'd9, 5'd7));
    put(i_type(OP_LOAD, 3'd0, 5'd8, 5'd1, 12'd14));
    put(r_type(7'h00, 3'd0, 5'd9, 5'd9, 5'd8));
    finish_program(5'd9);

    // Each store lands in the lanes picked by its low address bits.
    v    = 32'h89ABC5EF;
    old2 = fill_word(1026);
    old3 = fill_word(1027);
    e[0] = v;
    e[1] = (fill_word(1025) & 32'h00FF00FF) | {v[7:0], 8'h00, v[7:0], 8'h00};
    e[2] = {v[15:0], old2[15:0]};
    e[3] = {old3[31:24], v[7:0], v[15:0]};
    sum  = e[0] + sext8(e[1][15:8]) + {24'b0, e[1][31:24]} + sext16(e[2][31:16])
         + {16'b0, e[3][15:0]} + sext8(e[3][23:16]);
    run_program(name, sum);
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("%s word %0d", name, i), e[i], mem[1024 + i]);
    end
    if (we_log.size() != 6) begin
      $display("%s: expected 6 data writes but saw %0d.", name, we_log.size());
      errors++;
    end else begin
      foreach (be[i]) begin
        check_byte_en($sformatf("%s byte enables %0d", name, i), be[i], we_log[i]);
      end
    end
  endtask

  // Executed paths set bits in x10 and x11; instructions after taken jumps count in x12.
  task automatic control_flow(input string name);
    funct3_t  f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    reg_idx_t ta [6] = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
    reg_idx_t tb [6] = '{5'd3, 5'd2, 5'd1, 5'd2, 5'd2, 5'd1};
    reg_idx_t na [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
    reg_idx_t nb [6] = '{5'd2, 5'd3, 5'd2, 5'd1, 5'd1, 5'd2};
    int       link_jal;
    int       link_jalr;
    start_program();
    put(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
    put(i_type(OP_IMM, 3'd0, 5'd2, 5'd0, 12'hFFD));
    put(i_type(OP_IMM, 3'd0, 5'd3, 5'd0, 12'd5));
    put(i_type(OP_IMM, 3'd0, 5'd10, 5'd0, 12'd0));
    put(i_type(OP_IMM, 3'd0, 5'd11, 5'd0, 12'd0));
    put(i_type(OP_IMM, 3'd0, 5'd12, 5'd0, 12'd0));
    for (int i = 0; i < 6; i++) begin
      put(b_type(f3[i], ta[i], tb[i], 13'd8));
      put(i_type(OP_IMM, 3'd0, 5'd12, 5'd12, 12'd1));
      put(i_type(OP_IMM, 3'd6, 5'd10, 5'd10, 12'(1 << i)));
    end
    for (int i = 0; i < 6; i++) begin
      put(b_type(f3[i], na[i], nb[i], 13'd8));
      put(i_type(OP_IMM, 3'd6, 5'd11, 5'd11, 12'(1 << i)));
    end
    link_jal = wp * 4 + 4;
    put(j_type(5'd5, 21'd8));
    put(i_type(OP_IMM, 3'd0, 5'd12, 5'd12, 12'd1));
    put(i_type(OP_IMM, 3'd6, 5'd10, 5'd10, 12'h040));
    // The JALR offset is odd, so the target only lines up with bit 0 cleared.
    link_jalr = (wp + 1) * 4 + 4;
    put(i_type(OP_IMM, 3'd0, 5'd7, 5'd0, 12'(link_jalr)));
    put(i_type(OP_JALR, 3'd0, 5'd6, 5'd7, 12'd5));
    put(i_type(OP_IMM, 3'd0, 5'd12, 5'd12, 12'd1));
    put(i_type(OP_IMM, 3'd6, 5'd10, 5'd10, 12'h080));
    // A wrong link address leaves a nonzero difference in the poison count.
    put(i_type(OP_IMM, 3'd0, 5'd13, 5'd0, 12'(link_jal)));
    put(r_type(7'h20, 3'd0, 5'd14, 5'd5, 5'd13));
    put(r_type(7'h00, 3'd0, 5'd12, 5'd12, 5'd14));
    put(i_type(OP_IMM, 3'd0, 5'd13, 5'd0, 12'(link_jalr)));
    put(r_type(7'h20, 3'd0, 5'd14, 5'd6, 5'd13));
    put(r_type(7'h00, 3'd0, 5'd12, 5'd12, 5'd14));
    // An odd JALR target would carry bit 0 into every later pc, and AUIPC shows it.
    put(u_type(OP_AUIPC, 5'd15, 20'h0));
    put(i_type(OP_IMM, 3'd0, 5'd13, 5'd0, 12'((wp - 1) * 4)));
    put(r_type(7'h20, 3'd0, 5'd14, 5'd15, 5'd13));
    put(r_type(7'h00, 3'd0, 5'd12, 5'd12, 5'd14));
    put(i_type(OP_IMM, 3'd1, 5'd11, 5'd11, 12'd8));
    put(i_type(OP_IMM, 3'd1, 5'd12, 5'd12, 12'd16));
    put(r_type(7'h00, 3'd6, 5'd10, 5'd10, 5'd11));
    put(r_type(7'h00, 3'd6, 5'd10, 5'd10, 5'd12));
    finish_program(5'd10);
    run_program(name, 32'h0000_3FFF);
  endtask

  initial begin
    reset       = 1'b1;
    stall       = 1'b0;
    stall_mode  = 1'b0;
    icache_dout = '0;
    dcache_dout = '0;
    errors      = 0;
    wp          = 0;
    reset_state();
    alu_chain("alu");
    load_store("mem");
    control_flow("branch");
    stall_mode = 1'b1;
    alu_chain("alu with stalls");
    load_store("mem with stalls");
    control_flow("branch with stalls");
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_core.sv
tests/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST OK$" sim.log && exit 0 || exit 1
